/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_core -Mdir obj_dir -f tb.f
	./obj_dir/Vtb_core | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* core_decode.sv */
/*
 * Decode stage
 * Splits the instruction word, picks the ALU operation and operands,
 * flags illegal encodings and registers the execute-stage inputs.
 * Operands are resolved against the two younger results in flight.
 */

module core_decode #(
    parameter int unsigned REG_COUNT = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            instr_valid,
    input  core_pkg::instr_u                instr,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  core_pkg::data_t                 rs1_data,
    input  core_pkg::data_t                 rs2_data,
    input  logic                            fwd_valid,
    input  logic [core_pkg::REG_ADDR_W-1:0] fwd_rd,
    input  core_pkg::data_t                 fwd_data,
    input  logic                            res_valid,
    input  logic [core_pkg::REG_ADDR_W-1:0] res_rd,
    input  core_pkg::data_t                 res_data,
    output logic                            ex_valid,
    output core_pkg::alu_op_e               ex_op,
    output core_pkg::data_t                 ex_a,
    output core_pkg::data_t                 ex_b,
    output logic [core_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic                            illegal
);
    import core_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  is_op;
    logic                  is_op_imm;
    logic                  f7_ok;
    logic                  regs_ok;
    logic                  legal;
    alu_op_e               op;
    data_t                 imm_val;
    data_t                 b_sel;

    // Operand state carried into the execute cycle
    logic [REG_ADDR_W-1:0] rs1_q;
    logic [REG_ADDR_W-1:0] rs2_q;
    logic                  use_rs2_q;
    data_t                 a_q;
    data_t                 b_q;

    ////////////////////
    // Field extraction

    assign opcode = instr.r_view.opcode;
    assign funct3 = instr.r_view.funct3;
    assign funct7 = instr.r_view.funct7;
    assign rs1    = instr.r_view.rs1;
    assign rs2    = instr.r_view.rs2;
    assign rd     = instr.r_view.rd;

    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);

    assign rs1_addr = rs1;
    assign rs2_addr = rs2;

    assign imm_val = {{(XLEN-12){instr.i_view.imm12[11]}}, instr.i_view.imm12};

    // funct7 only matters for R-type and for the immediate shifts
    always_comb begin
        op    = ALU_ADD;
        f7_ok = 1'b0;
        case (funct3)
            3'b000: begin
                op    = (is_op && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                f7_ok = is_op_imm || funct7 == F7_ZERO || funct7 == F7_ALT;
            end
            3'b001: begin
                op    = ALU_SLL;
                f7_ok = (funct7 == F7_ZERO);
            end
            3'b010: begin
                op    = ALU_SLT;
                f7_ok = is_op_imm || funct7 == F7_ZERO;
            end
            3'b011: begin
                op    = ALU_SLTU;
                f7_ok = is_op_imm || funct7 == F7_ZERO;
            end
            3'b100: begin
                op    = ALU_XOR;
                f7_ok = is_op_imm || funct7 == F7_ZERO;
            end
            3'b101: begin
                op    = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                f7_ok = (funct7 == F7_ZERO) || (funct7 == F7_ALT);
            end
            3'b110: begin
                op    = ALU_OR;
                f7_ok = is_op_imm || funct7 == F7_ZERO;
            end
            default: begin
                op    = ALU_AND;
                f7_ok = is_op_imm || funct7 == F7_ZERO;
            end
        endcase
    end

    // Register indices beyond the implemented set are illegal
    assign regs_ok = (32'(rs1) < REG_COUNT) && (32'(rd) < REG_COUNT)
                   && (!is_op || 32'(rs2) < REG_COUNT);

    assign legal = (is_op || is_op_imm) && f7_ok && regs_ok;

    // Shift immediates take only the shamt field
    always_comb begin
        if (is_op) begin
            b_sel = rs2_data;
        end else if (funct3[1:0] == 2'b01) begin
            b_sel = data_t'(instr.r_view.rs2);
        end else begin
            b_sel = imm_val;
        end
    end

    ////////////////////
    // Stage register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            // rd of x0 never writes back
            ex_valid <= instr_valid && legal && (rd != '0);
            illegal  <= instr_valid && !legal;
        end
    end

    always_ff @(posedge clk) begin
        ex_op     <= op;
        ex_rd     <= rd;
        a_q       <= rs1_data;
        b_q       <= b_sel;
        rs1_q     <= rs1;
        rs2_q     <= rs2;
        use_rs2_q <= is_op;
    end

    ////////////////////
    // Forwarding

    // Execute register is one instruction ahead, result register two
    always_comb begin
        ex_a = a_q;
        if (fwd_valid && fwd_rd == rs1_q) begin
            ex_a = fwd_data;
        end else if (res_valid && res_rd == rs1_q) begin
            ex_a = res_data;
        end

        ex_b = b_q;
        if (use_rs2_q) begin
            if (fwd_valid && fwd_rd == rs2_q) begin
                ex_b = fwd_data;
            end else if (res_valid && res_rd == rs2_q) begin
                ex_b = res_data;
            end
        end
    end

endmodule

/* core_execute.sv */
/*
 * Execute stage
 * ALU for the RV32I register and immediate operations.
 * The registered result doubles as the first forwarding source.
 */

module core_execute (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ex_valid,
    input  core_pkg::alu_op_e               ex_op,
    input  core_pkg::data_t                 ex_a,
    input  core_pkg::data_t                 ex_b,
    input  logic [core_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic                            res_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] res_rd,
    output core_pkg::data_t                 res_data
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    data_t      alu_result;

    assign shamt       = ex_b[4:0];
    assign lt_signed   = $signed(ex_a) < $signed(ex_b);
    assign lt_unsigned = ex_a < ex_b;

    ////////////////////
    // ALU

    always_comb begin
        case (ex_op)
            ALU_ADD: begin
                alu_result = ex_a + ex_b;
            end
            ALU_SUB: begin
                alu_result = ex_a - ex_b;
            end
            ALU_SLL: begin
                alu_result = ex_a << shamt;
            end
            ALU_SLT: begin
                alu_result = data_t'(lt_signed);
            end
            ALU_SLTU: begin
                alu_result = data_t'(lt_unsigned);
            end
            ALU_XOR: begin
                alu_result = ex_a ^ ex_b;
            end
            ALU_SRL: begin
                alu_result = ex_a >> shamt;
            end
            ALU_SRA: begin
                // Arithmetic shift keeps the sign
                alu_result = data_t'($signed(ex_a) >>> shamt);
            end
            ALU_OR: begin
                alu_result = ex_a | ex_b;
            end
            ALU_AND: begin
                alu_result = ex_a & ex_b;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    ////////////////////
    // Stage register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        res_rd   <= ex_rd;
        res_data <= alu_result;
    end

endmodule

/* core_pkg.sv */
/*
 * Core package
 * Shared widths, the instruction word with its R-type and I-type
 * views, ALU operation codes and the accepted RV32I opcodes
 */

package core_pkg;

    ////////////////////
    // Widths

    localparam int unsigned XLEN = 32;
    localparam int unsigned REG_ADDR_W = 5;

    typedef logic [XLEN-1:0] data_t;

    ////////////////////
    // Instruction word

    // Same 32 bits, read as register-register or register-immediate
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r_view;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i_view;
    } instr_u;

    ////////////////////
    // ALU operations

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    ////////////////////
    // Opcodes

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct7 patterns, base and alternate (SUB, SRA, SRAI)
    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

/* core_regfile.sv */
/*
 * Integer register file
 * Two combinational read ports with write-through, one write port.
 * x0 always reads as zero.
 */

module core_regfile #(
    parameter int unsigned REG_COUNT = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic                            wr_en,
    input  logic [core_pkg::REG_ADDR_W-1:0] wr_addr,
    input  core_pkg::data_t                 wr_data,
    output core_pkg::data_t                 rs1_data,
    output core_pkg::data_t                 rs2_data
);
    import core_pkg::*;

    localparam int unsigned IDX_W = $clog2(REG_COUNT);

    data_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr[IDX_W-1:0]] <= wr_data;
        end
    end

    // Same-cycle write is visible on the read side
    function automatic data_t read_port(input logic [REG_ADDR_W-1:0] addr);
        data_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && wr_addr == addr) begin
            value = wr_data;
        end else begin
            value = regs[addr[IDX_W-1:0]];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

/* core_result.sv */
/*
 * Result stage
 * Last pipeline register, feeding write-back, the register file
 * write port and the second forwarding source
 */

module core_result (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            res_valid,
    input  logic [core_pkg::REG_ADDR_W-1:0] res_rd,
    input  core_pkg::data_t                 res_data,
    output logic                            wr_en,
    output logic [core_pkg::REG_ADDR_W-1:0] wr_addr,
    output core_pkg::data_t                 wr_data,
    output logic                            wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    output core_pkg::data_t                 wb_data
);
    import core_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= res_rd;
        wb_data <= res_data;
    end

    // Register file commits on the next edge
    assign wr_en   = wb_valid;
    assign wr_addr = wb_rd;
    assign wr_data = wb_data;

endmodule

/* core_top.sv */
/*
 * Integer core top level
 * Three-stage pipeline: decode, execute, result.
 * One instruction per cycle, write-back three cycles later.
 */

module core_top #(
    parameter int unsigned REG_COUNT = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            instr_valid,
    input  logic [31:0]                     instr,
    output logic                            wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
    output core_pkg::data_t                 wb_data,
    output logic                            illegal
);
    import core_pkg::*;

    // Register file ports
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    data_t                 rs1_data;
    data_t                 rs2_data;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    data_t                 wr_data;

    // Decode to execute
    logic                  ex_valid;
    alu_op_e               ex_op;
    data_t                 ex_a;
    data_t                 ex_b;
    logic [REG_ADDR_W-1:0] ex_rd;

    // Execute to result, also forwarded
    logic                  res_valid;
    logic [REG_ADDR_W-1:0] res_rd;
    data_t                 res_data;

    ////////////////////
    // Pipeline

    core_decode #(
        .REG_COUNT (REG_COUNT)
    ) core_decode_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr_u'(instr)),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .fwd_valid   (res_valid),
        .fwd_rd      (res_rd),
        .fwd_data    (res_data),
        .res_valid   (wb_valid),
        .res_rd      (wb_rd),
        .res_data    (wb_data),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_rd       (ex_rd),
        .illegal     (illegal)
    );

    core_regfile #(
        .REG_COUNT (REG_COUNT)
    ) core_regfile_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    core_execute core_execute_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_valid  (ex_valid),
        .ex_op     (ex_op),
        .ex_a      (ex_a),
        .ex_b      (ex_b),
        .ex_rd     (ex_rd),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data)
    );

    core_result core_result_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

/* tb.f */
core_pkg.sv
core_decode.sv
core_regfile.sv
core_execute.sv
core_result.sv
core_top.sv
tb_core.sv

/* tb_core.sv */
/*
 * Testbench for the integer core
 * Runs a directed table and a random instruction stream through the
 * pipeline and compares write-back and illegal pulses with a
 * reference register file and ALU
 */

module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          RAND_COUNT = 200;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam logic [6:0]  OPC_R      = 7'b0110011;
    localparam logic [6:0]  OPC_I      = 7'b0010011;
    localparam logic [6:0]  ALT        = 7'b0100000;

    // Row kinds as {valid, illegal, writes}
    localparam logic [2:0] ROW_IDLE    = 3'b000;
    localparam logic [2:0] ROW_WRITE   = 3'b101;
    localparam logic [2:0] ROW_NONE    = 3'b100;
    localparam logic [2:0] ROW_ILLEGAL = 3'b110;

    typedef struct packed {
        logic [31:0] word;
        logic        valid;
        logic        illegal;
        logic        writes;
    } stim_t;

    typedef struct packed {
        int          issue;
        logic        illegal;
        logic        writes;
        logic [4:0]  rd;
        logic [31:0] data;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        illegal;

    stim_t       stim_table[$];
    exp_t        exp_q[$];
    stim_t       idle_stim = '0;
    logic [31:0] ref_regs [32];
    logic [31:0] lfsr;
    int          cycle = 0;
    int          check_count = 0;
    int          error_count = 0;
    logic        checking = 1'b0;
    logic        table_ready = 1'b0;

    core_top #(
        .REG_COUNT (32)
    ) core_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////
    // Encoding and reference model

    function automatic logic [31:0] op_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_R};
    endfunction

    function automatic logic [31:0] op_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_I};
    endfunction

    // RV32I semantics, operands taken from the reference registers
    function automatic logic [31:0] ref_alu(input logic [31:0] word);
        logic               is_r;
        logic               alt;
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [31:0] sa;
        is_r = (word[6:0] == OPC_R);
        alt  = word[30];
        a    = ref_regs[word[19:15]];
        b    = is_r ? ref_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        sa   = a;
        case (word[14:12])
            3'd0: begin
                if (is_r && alt) begin
                    return a - b;
                end
                return a + b;
            end
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, ($signed(a) < $signed(b))};
            3'd3: return {31'd0, (a < b)};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic stim_t random_stim();
        stim_t       s;
        logic        is_imm;
        logic        alt;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        is_imm = 1'(take_bits(1));
        f3     = 3'(take_bits(3));
        rd     = 5'(take_bits(5));
        rs1    = 5'(take_bits(5));
        rs2    = 5'(take_bits(5));
        alt    = 1'(take_bits(1));
        if (is_imm) begin
            if (f3 == 3'd1) begin
                imm = {7'd0, rs2};
            end else if (f3 == 3'd5) begin
                imm = {(alt ? ALT : 7'd0), rs2};
            end else begin
                imm = 12'(take_bits(12));
            end
            s.word = op_i(imm, rs1, f3, rd);
        end else begin
            s.word = op_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? ALT : 7'd0, rs2, rs1, f3, rd);
        end
        s.valid   = 1'b1;
        s.illegal = 1'b0;
        s.writes  = (rd != 5'd0);
        return s;
    endfunction

    ////////////////////
    // Stimulus table

    task automatic add_row(input logic [31:0] word, input logic [2:0] kind);
        stim_t s;
        s.word    = word;
        s.valid   = kind[2];
        s.illegal = kind[1];
        s.writes  = kind[0];
        stim_table.push_back(s);
    endtask

    task automatic build_table();
        // Idle cycles with junk on the instruction bus
        add_row(32'h0000_0000, ROW_IDLE);
        add_row(32'hffff_ffff, ROW_IDLE);
        add_row(32'h0000_0013, ROW_IDLE);
        // Seed values, x2 from a negative immediate
        add_row(op_i(12'd100, 5'd0, 3'd0, 5'd1), ROW_WRITE);
        add_row(op_i(12'hff9, 5'd0, 3'd0, 5'd2), ROW_WRITE);
        add_row(op_i(12'h7ff, 5'd0, 3'd0, 5'd3), ROW_WRITE);
        add_row(op_i(12'd20, 5'd3, 3'd1, 5'd4), ROW_WRITE);
        add_row(op_i(12'h123, 5'd2, 3'd6, 5'd5), ROW_WRITE);
        // Register-register, ADD through AND
        add_row(op_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd6), ROW_WRITE);
        add_row(op_r(ALT, 5'd2, 5'd1, 3'd0, 5'd7), ROW_WRITE);
        add_row(op_r(7'd0, 5'd2, 5'd1, 3'd1, 5'd8), ROW_WRITE);
        add_row(op_r(7'd0, 5'd1, 5'd2, 3'd2, 5'd9), ROW_WRITE);
        add_row(op_r(7'd0, 5'd1, 5'd2, 3'd3, 5'd10), ROW_WRITE);
        add_row(op_r(7'd0, 5'd5, 5'd4, 3'd4, 5'd11), ROW_WRITE);
        add_row(op_r(7'd0, 5'd1, 5'd2, 3'd5, 5'd12), ROW_WRITE);
        add_row(op_r(ALT, 5'd1, 5'd2, 3'd5, 5'd13), ROW_WRITE);
        add_row(op_r(7'd0, 5'd2, 5'd3, 3'd6, 5'd14), ROW_WRITE);
        add_row(op_r(7'd0, 5'd2, 5'd5, 3'd7, 5'd15), ROW_WRITE);
        // Immediate forms
        add_row(op_i(12'hfff, 5'd2, 3'd2, 5'd16), ROW_WRITE);
        add_row(op_i(12'hfff, 5'd1, 3'd3, 5'd17), ROW_WRITE);
        add_row(op_i(12'hfff, 5'd1, 3'd4, 5'd18), ROW_WRITE);
        add_row(op_i(12'h0f0, 5'd2, 3'd7, 5'd19), ROW_WRITE);
        add_row(op_i(12'd3, 5'd2, 3'd5, 5'd20), ROW_WRITE);
        add_row(op_i(12'h403, 5'd2, 3'd5, 5'd21), ROW_WRITE);
        // Producer to consumer at distance 1, 2 and 3
        add_row(op_i(12'd5, 5'd0, 3'd0, 5'd22), ROW_WRITE);
        add_row(op_i(12'd1, 5'd22, 3'd0, 5'd22), ROW_WRITE);
        add_row(op_i(12'd9, 5'd0, 3'd0, 5'd23), ROW_WRITE);
        add_row(op_r(7'd0, 5'd23, 5'd22, 3'd0, 5'd24), ROW_WRITE);
        add_row(op_i(12'd0, 5'd0, 3'd0, 5'd0), ROW_NONE);
        add_row(op_r(ALT, 5'd23, 5'd24, 3'd0, 5'd25), ROW_WRITE);
        // x26 in both forwarding stages, the younger value must win
        add_row(op_i(12'd10, 5'd0, 3'd0, 5'd26), ROW_WRITE);
        add_row(op_i(12'd20, 5'd0, 3'd0, 5'd26), ROW_WRITE);
        add_row(op_r(7'd0, 5'd26, 5'd26, 3'd0, 5'd27), ROW_WRITE);
        // x0 as destination, then as source
        add_row(op_i(12'd55, 5'd1, 3'd0, 5'd0), ROW_NONE);
        add_row(op_r(7'd0, 5'd1, 5'd0, 3'd0, 5'd28), ROW_WRITE);
        // Illegal words aimed at live registers
        add_row({12'd4, 5'd1, 3'd2, 5'd5, 7'b0000011}, ROW_ILLEGAL);
        add_row(op_i(12'h423, 5'd1, 3'd5, 5'd6), ROW_ILLEGAL);
        add_row(op_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd7), ROW_ILLEGAL);
        add_row(op_r(ALT, 5'd2, 5'd1, 3'd4, 5'd8), ROW_ILLEGAL);
        add_row(op_i(12'h401, 5'd1, 3'd1, 5'd9), ROW_ILLEGAL);
        // Read back what the illegal words named
        add_row(op_r(7'd0, 5'd6, 5'd5, 3'd4, 5'd29), ROW_WRITE);
        add_row(op_r(7'd0, 5'd8, 5'd7, 3'd6, 5'd30), ROW_WRITE);
        add_row(op_r(7'd0, 5'd0, 5'd9, 3'd0, 5'd31), ROW_WRITE);
    endtask

    ////////////////////
    // Driver and checker

    task automatic issue(input stim_t s);
        exp_t e;
        @(posedge clk);
        #2;
        instr_valid = s.valid;
        instr       = s.word;
        e.issue     = cycle;
        e.illegal   = s.valid && s.illegal;
        e.writes    = s.valid && s.writes;
        e.rd        = s.word[11:7];
        e.data      = ref_alu(s.word);
        if (e.writes) begin
            ref_regs[e.rd] = e.data;
        end
        exp_q.push_back(e);
    endtask

    // Illegal is due one cycle after issue, write-back three
    task automatic check_outputs();
        exp_t e;
        logic exp_ill;
        logic exp_wb;
        e       = '0;
        exp_ill = 1'b0;
        exp_wb  = 1'b0;
        foreach (exp_q[i]) begin
            if (exp_q[i].issue == cycle - 1) begin
                exp_ill = exp_q[i].illegal;
            end
        end
        if (exp_q.size() > 0) begin
            if (exp_q[0].issue == cycle - 3) begin
                e      = exp_q.pop_front();
                exp_wb = e.writes;
            end
        end
        check_count++;
        assert (illegal === exp_ill) else begin
            error_count++;
            $display("ERROR %0t: illegal is %b, expected %b", $time, illegal, exp_ill);
        end
        check_count++;
        assert (wb_valid === exp_wb) else begin
            error_count++;
            $display("ERROR %0t: wb_valid is %b, expected %b", $time, wb_valid, exp_wb);
        end
        if (exp_wb) begin
            check_count++;
            assert (wb_rd === e.rd && wb_data === e.data) else begin
                error_count++;
                $display("ERROR %0t: write x%0d = %h, expected x%0d = %h",
                         $time, wb_rd, wb_data, e.rd, e.data);
            end
        end
    endtask

    always @(negedge clk) begin
        if (checking) begin
            check_outputs();
        end
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 32'd12;
        ref_regs    = '{default: '0};
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        rst_n    = 1'b1;
        checking = 1'b1;
        foreach (stim_table[i]) begin
            issue(stim_table[i]);
        end
        for (int i = 0; i < RAND_COUNT; i++) begin
            issue(random_stim());
        end
        repeat (3) issue(idle_stim);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Run length covers reset, the table, the random stream and the drain
    initial begin
        wait (table_ready);
        #((stim_table.size() + RAND_COUNT + 20) * 20);
        $display("Timeout: the run did not reach its end in the expected time");
        $display("Test failed");
        $finish;
    end

endmodule
